//--- source/branch_defs.svh
// branch subsystem sizing macros
`ifndef BRANCH_DEFS_SVH
`define BRANCH_DEFS_SVH

// datapath and pc width
`define BR_WORD 32

// btb depth, must stay a power of two
`define BTB_ENTRIES 16

// index bits taken from the pc just above the byte offset
`define BTB_IDX ($clog2(`BTB_ENTRIES))

// tag covers every pc bit above the index
// two low bits are the word offset and never stored
`define BTB_TAG (`BR_WORD - `BTB_IDX - 2)

`endif

//--- source/branch_pkg.sv
// branch unit shared types
`include "branch_defs.svh"

package branch_pkg;

  // condition codes follow the rv32i funct3 field
  // code 010 is unused by the isa, so it marks no branch
  typedef enum logic [2:0] {
    BT_BEQ  = 3'b000,
    BT_BNE  = 3'b001,
    BT_NONE = 3'b010,
    BT_BLT  = 3'b100,
    BT_BGE  = 3'b101,
    BT_BLTU = 3'b110,
    BT_BGEU = 3'b111
  } branch_type_t;

  // control transfer class of the issued instruction
  typedef enum logic [1:0] {
    JK_BRANCH = 2'd0,
    JK_JAL    = 2'd1,
    JK_JALR   = 2'd2,
    JK_RSVD   = 2'd3
  } jump_kind_t;

  // operands as they leave issue, imm already sign extended
  typedef struct packed {
    jump_kind_t          jump_kind;
    branch_type_t        branch_type;
    logic [`BR_WORD-1:0] current_pc;
    logic [`BR_WORD-1:0] reg_a;
    logic [`BR_WORD-1:0] reg_b;
    logic [`BR_WORD-1:0] imm;
    // direction fetch assumed for this instruction
    logic                predicted_outcome;
  } branch_issue_t;

  // resolution seen by the rest of the pipeline
  typedef struct packed {
    logic                branch_outcome;
    logic                miss;
    logic                resolved;
    logic                br_jump;
    logic [`BR_WORD-1:0] correct_pc;
    logic [`BR_WORD-1:0] branch_target;
    // link value for jal and jalr
    logic [`BR_WORD-1:0] jump_wdat;
  } branch_result_t;

  // training request towards the btb
  typedef struct packed {
    logic [`BR_WORD-1:0] update_pc;
    logic [`BR_WORD-1:0] target;
    logic                taken;
  } btb_update_t;

endpackage

//--- source/fu_branch.sv
// branch and jump resolution unit
`timescale 1ns/100ps
`include "branch_defs.svh"

module fu_branch (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       enable,
  input  branch_pkg::branch_issue_t  issue,
  output branch_pkg::branch_result_t result,
  output logic                       update_btb,
  output branch_pkg::btb_update_t    update
);
  import branch_pkg::*;

  // compare stage flags
  logic                cmp_eq;
  logic                cmp_lt;
  logic                cmp_ltu;
  logic                outcome;

  // address adders
  logic [`BR_WORD-1:0] pc_plus4;
  logic [`BR_WORD-1:0] pc_plus_imm;
  logic [`BR_WORD-1:0] reg_plus_imm;

  // one update per branch pc
  logic                is_branch;
  logic                first_update;
  logic                btb_updated;
  logic [`BR_WORD-1:0] last_branch_pc;

  // value the result register loads when not clearing
  branch_result_t      nxt_result;
  logic                nxt_update_btb;

  assign pc_plus4     = issue.current_pc + `BR_WORD'(4);
  assign pc_plus_imm  = issue.current_pc + issue.imm;
  // jalr target, the low bit is left to the fetch side
  assign reg_plus_imm = issue.reg_a + issue.imm;

  // one equality and two magnitude compares serve all six conditions
  always_comb begin : compare
    cmp_eq  = issue.reg_a == issue.reg_b;
    cmp_lt  = $signed(issue.reg_a) < $signed(issue.reg_b);
    cmp_ltu = issue.reg_a < issue.reg_b;
  end

  // direction picked by condition code
  always_comb begin : outcome_sel
    case (issue.branch_type)
      BT_BEQ:  outcome = cmp_eq;
      BT_BNE:  outcome = !cmp_eq;
      BT_BLT:  outcome = cmp_lt;
      BT_BGE:  outcome = !cmp_lt;
      BT_BLTU: outcome = cmp_ltu;
      BT_BGEU: outcome = !cmp_ltu;
      default: outcome = 1'b0;
    endcase
  end

  assign is_branch = issue.jump_kind == JK_BRANCH;

  // repeat of the same pc while armed gets no second update
  assign first_update = !btb_updated || (issue.current_pc != last_branch_pc);

  always_comb begin : resolve
    nxt_result            = '0;
    // idle cycles still point at the fall-through pc
    nxt_result.correct_pc = pc_plus4;
    nxt_update_btb        = 1'b0;
    if (enable) begin
      case (issue.jump_kind)
        JK_BRANCH: begin
          nxt_result.branch_outcome = outcome;
          nxt_result.branch_target  = pc_plus_imm;
          nxt_result.correct_pc     = outcome ? pc_plus_imm : pc_plus4;
          nxt_result.miss           = outcome != issue.predicted_outcome;
          // a correct guess is resolved right away
          nxt_result.resolved       = outcome == issue.predicted_outcome;
          nxt_update_btb            = first_update;
        end
        JK_JAL: begin
          nxt_result.br_jump    = 1'b1;
          nxt_result.jump_wdat  = pc_plus4;
          nxt_result.correct_pc = pc_plus_imm;
          nxt_result.resolved   = 1'b1;
        end
        JK_JALR: begin
          nxt_result.br_jump    = 1'b1;
          nxt_result.jump_wdat  = pc_plus4;
          nxt_result.correct_pc = reg_plus_imm;
          nxt_result.resolved   = 1'b1;
        end
        default: begin
          // reserved kind, flagged as a jump but never resolved
          nxt_result.br_jump = 1'b1;
        end
      endcase
    end
  end

  // result register, self clearing after any miss or resolve
  // an issue landing on the clearing edge is flushed with it
  always_ff @(posedge CLK, negedge nRST) begin : result_reg
    if (!nRST) begin
      result     <= '0;
      update_btb <= 1'b0;
    end else if (result.miss || result.resolved) begin
      result     <= '0;
      update_btb <= 1'b0;
    end else begin
      result     <= nxt_result;
      update_btb <= nxt_update_btb;
    end
  end

  // training payload, only sampled by the btb under update_btb
  always_ff @(posedge CLK) begin : update_reg
    update.update_pc <= issue.current_pc;
    update.target    <= pc_plus_imm;
    update.taken     <= outcome;
  end

  // update guard
  // any enabled branch arms it, anything else rearms
  always_ff @(posedge CLK, negedge nRST) begin : guard_reg
    if (!nRST) begin
      btb_updated    <= 1'b0;
      last_branch_pc <= '0;
    end else if (enable && is_branch) begin
      btb_updated    <= 1'b1;
      last_branch_pc <= issue.current_pc;
    end else begin
      btb_updated    <= 1'b0;
    end
  end

endmodule

//--- source/btb.sv
// direct-mapped branch target buffer
`timescale 1ns/100ps
`include "branch_defs.svh"

module btb (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    update_btb,
  input  branch_pkg::btb_update_t update,
  input  logic [`BR_WORD-1:0]     lookup_pc,
  output logic                    pred_taken,
  output logic [`BR_WORD-1:0]     pred_target
);

  // per entry state
  logic [`BTB_ENTRIES-1:0] valid;
  logic [1:0]              cnt     [`BTB_ENTRIES];
  logic [`BTB_TAG-1:0]     tags    [`BTB_ENTRIES];
  logic [`BR_WORD-1:0]     targets [`BTB_ENTRIES];

  // lookup side
  logic [`BTB_IDX-1:0]     rd_idx;
  logic [`BTB_TAG-1:0]     rd_tag;
  logic                    rd_hit;

  // update side
  logic [`BTB_IDX-1:0]     wr_idx;
  logic [`BTB_TAG-1:0]     wr_tag;
  logic                    wr_hit;
  logic [1:0]              wr_cnt;
  logic [1:0]              nxt_cnt;

  // pc split, word offset dropped
  assign rd_idx = lookup_pc[`BTB_IDX+1:2];
  assign rd_tag = lookup_pc[`BR_WORD-1:`BTB_IDX+2];
  assign wr_idx = update.update_pc[`BTB_IDX+1:2];
  assign wr_tag = update.update_pc[`BR_WORD-1:`BTB_IDX+2];

  // fetch lookup, purely combinational
  assign rd_hit     = valid[rd_idx] && (tags[rd_idx] == rd_tag);
  assign pred_taken = rd_hit && cnt[rd_idx][1];

  // stored target on any hit, whatever the counter says
  // a miss falls through to the next word
  assign pred_target = rd_hit ? targets[rd_idx] : lookup_pc + `BR_WORD'(4);

  // does the branch being trained own its slot
  assign wr_hit = valid[wr_idx] && (tags[wr_idx] == wr_tag);
  assign wr_cnt = cnt[wr_idx];

  // 2-bit saturating counter step
  always_comb begin : cnt_next
    if (!wr_hit) begin
      // fresh install starts weak in the observed direction
      nxt_cnt = update.taken ? 2'b10 : 2'b01;
    end else if (update.taken) begin
      nxt_cnt = (wr_cnt == 2'b11) ? 2'b11 : wr_cnt + 2'd1;
    end else begin
      nxt_cnt = (wr_cnt == 2'b00) ? 2'b00 : wr_cnt - 2'd1;
    end
  end

  // valid bits and counters
  // counters come out of reset weakly not taken
  always_ff @(posedge CLK, negedge nRST) begin : ctrl_reg
    if (!nRST) begin
      valid <= '0;
      for (int i = 0; i < `BTB_ENTRIES; i++) begin
        cnt[i] <= 2'b01;
      end
    end else if (update_btb) begin
      valid[wr_idx] <= 1'b1;
      cnt[wr_idx]   <= nxt_cnt;
    end
  end

  // tag and target storage
  // target only written on taken, so a not-taken install keeps the old one
  always_ff @(posedge CLK) begin : mem_write
    if (update_btb) begin
      tags[wr_idx] <= wr_tag;
      if (update.taken) begin
        targets[wr_idx] <= update.target;
      end
    end
  end

endmodule

//--- source/branch_top.sv
// branch resolution and prediction top level
`timescale 1ns/100ps
`include "branch_defs.svh"

module branch_top (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       enable,
  input  branch_pkg::branch_issue_t  issue,
  input  logic [`BR_WORD-1:0]        lookup_pc,
  output branch_pkg::branch_result_t result,
  output logic                       pred_taken,
  output logic [`BR_WORD-1:0]        pred_target
);
  import branch_pkg::*;

  // training path from the resolver into the predictor
  logic        update_btb;
  btb_update_t update;

  // resolves one cycle after issue
  fu_branch u_fu_branch (
    .CLK        (CLK),
    .nRST       (nRST),
    .enable     (enable),
    .issue      (issue),
    .result     (result),
    .update_btb (update_btb),
    .update     (update)
  );

  // written one edge after the request
  // fetch sees the new entry two edges after issue
  btb u_btb (
    .CLK         (CLK),
    .nRST        (nRST),
    .update_btb  (update_btb),
    .update      (update),
    .lookup_pc   (lookup_pc),
    .pred_taken  (pred_taken),
    .pred_target (pred_target)
  );

endmodule

//--- test/branch_assertions.sv
// branch subsystem bound checks
`timescale 1ns/100ps
`include "branch_defs.svh"

module branch_assertions (
  input logic                       CLK,
  input logic                       nRST,
  input logic                       enable,
  input branch_pkg::branch_issue_t  issue,
  input logic [`BR_WORD-1:0]        lookup_pc,
  input branch_pkg::branch_result_t result,
  input logic                       pred_taken,
  input logic [`BR_WORD-1:0]        pred_target
);
  import branch_pkg::*;

  // failed assertion count, read by the testbench
  int unsigned err_cnt = 0;

  // expected result for the current issue
  branch_result_t exp_res;
  branch_result_t exp_q;
  logic           exp_dir;
  logic           clr;

  // shadow predictor
  logic [`BTB_ENTRIES-1:0] m_valid;
  logic [1:0]              m_cnt [`BTB_ENTRIES];
  logic [`BTB_TAG-1:0]     m_tag [`BTB_ENTRIES];
  logic [`BR_WORD-1:0]     m_tgt [`BTB_ENTRIES];
  // training in flight and the one-update guard
  logic                    p_valid;
  logic                    p_taken;
  logic [`BR_WORD-1:0]     p_pc;
  logic [`BR_WORD-1:0]     p_tgt;
  logic                    g_armed;
  logic [`BR_WORD-1:0]     g_pc;
  logic [`BTB_IDX-1:0]     l_idx;
  logic [`BTB_IDX-1:0]     p_idx;
  logic                    exp_hit;
  logic                    exp_taken;
  logic [`BR_WORD-1:0]     exp_target;

  assign clr = result.miss || result.resolved;

  always_comb begin
    case (issue.branch_type)
      BT_BEQ:  exp_dir = issue.reg_a == issue.reg_b;
      BT_BNE:  exp_dir = issue.reg_a != issue.reg_b;
      BT_BLT:  exp_dir = $signed(issue.reg_a) < $signed(issue.reg_b);
      BT_BGE:  exp_dir = $signed(issue.reg_a) >= $signed(issue.reg_b);
      BT_BLTU: exp_dir = issue.reg_a < issue.reg_b;
      BT_BGEU: exp_dir = issue.reg_a >= issue.reg_b;
      default: exp_dir = 1'b0;
    endcase
    exp_res = '0;
    exp_res.correct_pc = issue.current_pc + 32'd4;
    if (enable && issue.jump_kind == JK_BRANCH) begin
      exp_res.branch_outcome = exp_dir;
      exp_res.branch_target  = issue.current_pc + issue.imm;
      if (exp_dir) exp_res.correct_pc = issue.current_pc + issue.imm;
      exp_res.miss     = exp_dir ^ issue.predicted_outcome;
      exp_res.resolved = !(exp_dir ^ issue.predicted_outcome);
    end else if (enable && issue.jump_kind != JK_RSVD) begin
      exp_res.br_jump   = 1'b1;
      exp_res.jump_wdat = issue.current_pc + 32'd4;
      exp_res.resolved  = 1'b1;
      // jalr is register relative, jal pc relative
      exp_res.correct_pc = (issue.jump_kind == JK_JALR) ? issue.reg_a + issue.imm
                                                        : issue.current_pc + issue.imm;
    end else if (enable) begin
      exp_res.br_jump = 1'b1;
    end
  end

  // lookup expectation from the shadow state
  assign l_idx      = lookup_pc[`BTB_IDX+1:2];
  assign p_idx      = p_pc[`BTB_IDX+1:2];
  assign exp_hit    = m_valid[l_idx] && m_tag[l_idx] == lookup_pc[`BR_WORD-1:`BTB_IDX+2];
  assign exp_taken  = exp_hit && m_cnt[l_idx][1];
  // any hit returns the stored target
  assign exp_target = exp_hit ? m_tgt[l_idx] : lookup_pc + 32'd4;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      exp_q   <= '0;
      m_valid <= '0;
      p_valid <= 1'b0;
      g_armed <= 1'b0;
      g_pc    <= '0;
      for (int i = 0; i < `BTB_ENTRIES; i++) m_cnt[i] <= 2'b01;
    end else begin
      exp_q   <= exp_res;
      g_armed <= enable && issue.jump_kind == JK_BRANCH;
      if (enable && issue.jump_kind == JK_BRANCH) g_pc <= issue.current_pc;
      // dropped issues still arm the guard but never train
      p_valid <= enable && issue.jump_kind == JK_BRANCH && !clr
                 && (!g_armed || issue.current_pc != g_pc);
      p_pc    <= issue.current_pc;
      p_tgt   <= issue.current_pc + issue.imm;
      p_taken <= exp_dir;
      if (p_valid) begin
        m_valid[p_idx] <= 1'b1;
        m_tag[p_idx]   <= p_pc[`BR_WORD-1:`BTB_IDX+2];
        if (p_taken) m_tgt[p_idx] <= p_tgt;
        if (!m_valid[p_idx] || m_tag[p_idx] != p_pc[`BR_WORD-1:`BTB_IDX+2])
          m_cnt[p_idx] <= p_taken ? 2'b10 : 2'b01;
        else if (p_taken && m_cnt[p_idx] != 2'b11)
          m_cnt[p_idx] <= m_cnt[p_idx] + 2'd1;
        else if (!p_taken && m_cnt[p_idx] != 2'b00)
          m_cnt[p_idx] <= m_cnt[p_idx] - 2'd1;
      end
    end
  end

  // held in reset, everything clear and no prediction
  a_reset: assert property (@(posedge CLK) !nRST |->
      result == '0 && !pred_taken && pred_target == lookup_pc + 32'd4)
    else begin err_cnt++; $error("[ERROR] reset: expected clear actual %h", $sampled(result)); end

  // edge after a miss or resolve flushes
  a_clear: assert property (@(posedge CLK) disable iff (!nRST)
      $past(nRST) && $past(clr) |-> result == '0)
    else begin err_cnt++; $error("[ERROR] clear: expected 0 actual %h", $sampled(result)); end

  // resolution of branches, jumps, reserved and idle cycles
  a_resolve: assert property (@(posedge CLK) disable iff (!nRST)
      $past(nRST) && !$past(clr) |-> result == $past(exp_res))
    else begin
      err_cnt++;
      $error("[ERROR] resolve: expected %h actual %h", $sampled(exp_q), $sampled(result));
    end

  a_pred_dir: assert property (@(posedge CLK) disable iff (!nRST) pred_taken == exp_taken)
    else begin
      err_cnt++;
      $error("[ERROR] btb direction: expected %b actual %b", $sampled(exp_taken),
             $sampled(pred_taken));
    end

  a_pred_tgt: assert property (@(posedge CLK) disable iff (!nRST) pred_target == exp_target)
    else begin
      err_cnt++;
      $error("[ERROR] btb target: expected %h actual %h", $sampled(exp_target),
             $sampled(pred_target));
    end

endmodule

bind branch_top branch_assertions u_asrt (
  .CLK         (CLK),
  .nRST        (nRST),
  .enable      (enable),
  .issue       (issue),
  .lookup_pc   (lookup_pc),
  .result      (result),
  .pred_taken  (pred_taken),
  .pred_target (pred_target)
);

//--- test/branch_tb.sv
// branch subsystem testbench
`timescale 1ns/100ps
`include "branch_defs.svh"

module branch_tb;
  import branch_pkg::*;

  logic                CLK;
  logic                nRST;
  logic                enable;
  branch_issue_t       issue;
  logic [`BR_WORD-1:0] lookup_pc;
  branch_result_t      result;
  logic                pred_taken;
  logic [`BR_WORD-1:0] pred_target;

  int unsigned         timeouts;
  int unsigned         tests;
  branch_type_t        conds [6];

  branch_top u_dut (
    .CLK         (CLK),
    .nRST        (nRST),
    .enable      (enable),
    .issue       (issue),
    .lookup_pc   (lookup_pc),
    .result      (result),
    .pred_taken  (pred_taken),
    .pred_target (pred_target)
  );

  // 40 ns clock
  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // one enabled cycle, then back to idle
  task automatic drive_issue(input jump_kind_t k, input branch_type_t t,
                             input logic [31:0] pc, input logic [31:0] a,
                             input logic [31:0] b, input logic [31:0] imm,
                             input logic pred);
    @(posedge CLK);
    #2;
    issue.jump_kind         = k;
    issue.branch_type       = t;
    issue.current_pc        = pc;
    issue.reg_a             = a;
    issue.reg_b             = b;
    issue.imm               = imm;
    issue.predicted_outcome = pred;
    enable                  = 1'b1;
    @(posedge CLK);
    #2;
    enable = 1'b0;
  endtask

  // result shows up one edge after issue
  task automatic await_result;
    int n;
    n = 0;
    while (!(result.miss || result.resolved || result.br_jump) && n < 8) begin
      @(posedge CLK);
      #2;
      n++;
    end
    if (n >= 8) begin
      timeouts++;
      $display("no result from the branch unit within 8 cycles");
    end
    // let the self clear happen
    @(posedge CLK);
    #2;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge CLK);
    #2;
  endtask

  task automatic report_phase(input string name);
    tests++;
    $display("phase %0d %s done", tests, name);
  endtask

  function automatic logic [31:0] rand_pc();
    return $urandom & 32'h0000_fffc;
  endfunction

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pc;
    logic [31:0] imm;
    void'($urandom(36));
    timeouts  = 0;
    tests     = 0;
    conds     = '{BT_BEQ, BT_BNE, BT_BLT, BT_BGE, BT_BLTU, BT_BGEU};
    nRST      = 1'b0;
    enable    = 1'b0;
    issue     = '0;
    lookup_pc = 32'h100;
    repeat (5) @(posedge CLK);
    #2;
    nRST = 1'b1;

    // lookups into an empty btb
    for (int i = 0; i < 8; i++) begin
      lookup_pc = rand_pc();
      idle_cycles(1);
    end
    report_phase("reset");

    // six conditions, random operands, some equal
    for (int c = 0; c < 6; c++) begin
      for (int r = 0; r < 6; r++) begin
        a   = $urandom;
        b   = (r % 3 == 0) ? a : $urandom;
        imm = ($urandom & 32'h0000_0ffc) - 32'h800;
        lookup_pc = rand_pc();
        drive_issue(JK_BRANCH, conds[c], rand_pc(), a, b, imm, r[0]);
        await_result();
      end
    end
    report_phase("branch resolution");

    // back to back issues, the second one is flushed
    for (int i = 0; i < 4; i++) begin
      @(posedge CLK);
      #2;
      issue.jump_kind         = JK_BRANCH;
      issue.branch_type       = BT_BNE;
      issue.current_pc        = rand_pc();
      issue.reg_a             = $urandom;
      issue.reg_b             = $urandom;
      issue.imm               = 32'h40;
      issue.predicted_outcome = i[0];
      enable                  = 1'b1;
      idle_cycles(1);
      // enable stays high across the clearing edge
      await_result();
      enable = 1'b0;
    end
    report_phase("miss and resolve");

    // jal, jalr and the reserved kind
    for (int i = 0; i < 3; i++) begin
      drive_issue(JK_JAL, BT_NONE, rand_pc(), $urandom, $urandom, 32'h0000_0120, 1'b0);
      await_result();
      drive_issue(JK_JALR, BT_NONE, rand_pc(), $urandom, $urandom, 32'hffff_fff0, 1'b0);
      await_result();
      drive_issue(JK_RSVD, BT_NONE, rand_pc(), $urandom, $urandom, 32'h8, 1'b0);
      await_result();
    end
    report_phase("jumps");

    // one pc held over several enabled cycles
    pc        = 32'h0000_2040;
    lookup_pc = pc;
    @(posedge CLK);
    #2;
    issue.jump_kind         = JK_BRANCH;
    issue.branch_type       = BT_BEQ;
    issue.current_pc        = pc;
    issue.reg_a             = 32'h55;
    issue.reg_b             = 32'h55;
    issue.imm               = 32'h100;
    issue.predicted_outcome = 1'b0;
    enable                  = 1'b1;
    idle_cycles(5);
    enable = 1'b0;
    idle_cycles(3);
    // a single not-taken step shows whether one or two updates landed
    drive_issue(JK_BRANCH, BT_BEQ, pc, 32'h1, 32'h2, 32'h100, 1'b1);
    await_result();
    idle_cycles(2);
    report_phase("update guard");

    // learn taken twice, then unlearn with two not-taken
    pc        = 32'h0000_3080;
    lookup_pc = pc;
    for (int i = 0; i < 2; i++) begin
      drive_issue(JK_BRANCH, BT_BLTU, pc, 32'h1, 32'h9, 32'h200, i[0]);
      await_result();
      idle_cycles(2);
    end
    idle_cycles(1);
    for (int i = 0; i < 2; i++) begin
      drive_issue(JK_BRANCH, BT_BLTU, pc, 32'h9, 32'h1, 32'h200, 1'b1);
      await_result();
      idle_cycles(2);
    end
    report_phase("btb learning");

    idle_cycles(3);
    $display("tests %0d, assertion errors %0d, timeouts %0d",
             tests, u_dut.u_asrt.err_cnt, timeouts);
    if (u_dut.u_asrt.err_cnt == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+source
source/branch_pkg.sv
source/fu_branch.sv
source/btb.sv
source/branch_top.sv
test/branch_assertions.sv
test/branch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the branch subsystem simulation with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert \
  --top-module branch_tb \
  -f sim.f \
  -o branch_sim \
  && ./obj_dir/branch_sim | tee sim.log

grep -qx "Test OK" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
